//--- pf_pkg.sv
// Shared definitions for the instruction prefetch unit
// Address and data widths, buffer depth and derived count widths
// Controller state encoding

`default_nettype none

package pf_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Instruction address width
  localparam int unsigned PF_ADDR_W = 32;

  // Instruction word width
  localparam int unsigned PF_DATA_W = 32;

  ////////////////////
  // Buffer sizing
  ////////////////////

  // Buffer entries, also the limit on buffered plus live outstanding words
  // Any power of two of 2 or more
  localparam int unsigned PF_DEPTH = 4;

  // Occupancy and outstanding counts, must hold PF_DEPTH itself
  localparam int unsigned PF_CNT_W = $clog2(PF_DEPTH + 1);

  // Buffer read and write pointers, wrap naturally at PF_DEPTH
  localparam int unsigned PF_PTR_W = $clog2(PF_DEPTH);

  // Byte step between sequential instruction words
  localparam int unsigned PF_WORD_INCR = 4;

  ////////////////////
  // Controller state
  ////////////////////

  // IDLE        issuing sequentially or waiting for credit
  // BRANCH_WAIT branch target held until the bus accepts it
  typedef enum logic {
    IDLE        = 1'b0,
    BRANCH_WAIT = 1'b1
  } prefetch_state_e;

endpackage

`default_nettype wire

//--- pf_ctrl_fsm.sv
// Prefetch controller FSM
// Request credit rule, branch target holding and flush generation
// Concurrent assertions on request and branch behavior

`timescale 1ns/1ps
`default_nettype none

module pf_ctrl_fsm import pf_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  // Core fetch side
  input  logic                fetch_valid_i,
  input  logic                fetch_branch_i,
  // Bus request handshake
  input  logic                trans_ready_i,
  // Buffer occupancy and live transactions in flight
  input  logic [PF_CNT_W-1:0] count_i,
  input  logic [PF_CNT_W-1:0] outstanding_i,
  output logic                trans_valid_o,
  output logic                fetch_ready_o,
  // Strobes to the counters, filter and buffer
  output logic                issue_o,
  output logic                flush_o,
  output logic                sel_branch_o
);

  prefetch_state_e state_q;
  prefetch_state_e state_d;

  // Buffered plus live outstanding, one bit wider than either count
  logic [PF_CNT_W:0] inflight_sum;
  logic              credit_ok;
  logic              accept;

  ////////////////////
  // Credit rule
  ////////////////////

  assign inflight_sum = {1'b0, count_i} + {1'b0, outstanding_i};

  // Branch cycle and a held target count as empty
  // The flush clears the buffer and old responses get discarded, not stored
  assign credit_ok = fetch_branch_i || (state_q == BRANCH_WAIT) ||
                     (inflight_sum < PF_DEPTH);

  assign trans_valid_o = fetch_valid_i && credit_ok;
  assign accept        = trans_valid_o && trans_ready_i;
  assign fetch_ready_o = accept;
  assign issue_o       = accept;

  // Flush is the branch pulse itself
  assign flush_o      = fetch_branch_i;
  // Target goes to the bus combinationally in the branch cycle only
  // In BRANCH_WAIT the fetch counter already holds it
  assign sel_branch_o = fetch_branch_i;

  ////////////////////
  // State register
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (fetch_branch_i && !accept) begin
          state_d = BRANCH_WAIT;
        end
      end
      BRANCH_WAIT: begin
        // A fresh branch just replaces the held target
        if (accept) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Set once the core has given its first branch
  logic seen_branch_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_branch_q <= 1'b0;
    end else if (fetch_branch_i) begin
      seen_branch_q <= 1'b1;
    end
  end

  // No request without the core asking for one
  a_trans_valid: assert property (@(posedge clk) disable iff (!rst_n)
    trans_valid_o |-> fetch_valid_i)
    else $error("trans_valid_o high while fetch_valid_i low");

  // Core sees every acceptance
  a_fetch_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (trans_valid_o && trans_ready_i) |-> fetch_ready_o)
    else $error("fetch_ready_o low on an accepted transaction");

  // Stream must start at a branch target, never at the reset address
  a_first_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    trans_valid_o |-> (fetch_branch_i || seen_branch_q))
    else $error("first request after reset does not follow a branch");

  // Branch during BRANCH_WAIT replaces the target, nothing of the old stream is kept
  a_branch_wait_replace: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == BRANCH_WAIT && fetch_branch_i && !accept)
      |=> (state_q == BRANCH_WAIT && count_i == '0 && outstanding_i == '0))
    else $error("branch in BRANCH_WAIT did not replace the held target");

endmodule

`default_nettype wire

//--- pf_addr_cnt.sv
// Fetch address counter for bus requests
// Output instruction address counter for the core
// Assertions on request address alignment and sequential stepping

`timescale 1ns/1ps
`default_nettype none

module pf_addr_cnt import pf_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_branch_i,
  input  logic [PF_ADDR_W-1:0] fetch_branch_addr_i,
  input  logic                 sel_branch_i,
  // Bus acceptance and instruction take strobes
  input  logic                 issue_i,
  input  logic                 pop_i,
  output logic [PF_ADDR_W-1:0] trans_addr_o,
  output logic [PF_ADDR_W-1:0] instr_addr_o
);

  logic [PF_ADDR_W-1:0] fetch_addr_q;
  logic [PF_ADDR_W-1:0] instr_addr_q;

  // Bypass the counter in the branch cycle
  assign trans_addr_o = sel_branch_i ? fetch_branch_addr_i : fetch_addr_q;
  assign instr_addr_o = instr_addr_q;

  // Fetch counter
  // Branch accepted at once moves straight past the target
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_addr_q <= '0;
    end else if (issue_i) begin
      fetch_addr_q <= trans_addr_o + PF_ADDR_W'(PF_WORD_INCR);
    end else if (fetch_branch_i) begin
      fetch_addr_q <= fetch_branch_addr_i;
    end
  end

  // Output counter, a pop in the branch cycle belongs to the old stream
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_addr_q <= '0;
    end else if (fetch_branch_i) begin
      instr_addr_q <= fetch_branch_addr_i;
    end else if (pop_i) begin
      instr_addr_q <= instr_addr_q + PF_ADDR_W'(PF_WORD_INCR);
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Last accepted address, valid only after an acceptance in the current stream
  logic [PF_ADDR_W-1:0] prev_addr_q;
  logic                 seq_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_addr_q <= '0;
      seq_q       <= 1'b0;
    end else if (issue_i) begin
      prev_addr_q <= trans_addr_o;
      seq_q       <= 1'b1;
    end else if (fetch_branch_i) begin
      seq_q       <= 1'b0;
    end
  end

  a_trans_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    issue_i |-> (trans_addr_o[1:0] == 2'b00))
    else $error("trans_addr_o not word aligned");

  a_addr_incr: assert property (@(posedge clk) disable iff (!rst_n)
    (issue_i && !sel_branch_i && seq_q)
      |-> (trans_addr_o == prev_addr_q + PF_ADDR_W'(PF_WORD_INCR)))
    else $error("sequential request address did not step by one word");

endmodule

`default_nettype wire

//--- pf_resp_filter.sv
// Bus response filter
// Live outstanding count and discard count for flushed streams
// Assertion on unexpected responses

`timescale 1ns/1ps
`default_nettype none

module pf_resp_filter import pf_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 issue_i,
  input  logic                 flush_i,
  // In-order response strobe and word
  input  logic                 resp_valid_i,
  input  logic [PF_DATA_W-1:0] resp_rdata_i,
  // Buffer write port
  output logic                 wr_en_o,
  output logic [PF_DATA_W-1:0] wr_data_o,
  output logic [PF_CNT_W-1:0]  outstanding_o
);

  // Transactions whose words will be stored
  logic [PF_CNT_W-1:0] live_q;
  logic [PF_CNT_W-1:0] live_d;
  // Responses still owed to flushed streams
  // One bit wider, a second flush can land before the first drains
  logic [PF_CNT_W:0]   disc_q;
  logic [PF_CNT_W:0]   disc_d;

  logic                dropping;
  logic                keep;

  // Discards always come first, responses arrive in order
  assign dropping = (disc_q != '0);

  // Response in the flush cycle is from the old stream
  // The new target cannot answer before the next cycle
  assign keep = resp_valid_i && !dropping && !flush_i;

  assign wr_en_o       = keep;
  assign wr_data_o     = resp_rdata_i;
  assign outstanding_o = live_q;

  ////////////////////
  // Count update
  ////////////////////

  always_comb begin
    if (flush_i) begin
      // Everything in flight now is old, only a same-cycle target stays live
      disc_d = disc_q + {1'b0, live_q} - (PF_CNT_W + 1)'(resp_valid_i);
      live_d = PF_CNT_W'(issue_i);
    end else begin
      disc_d = disc_q - (PF_CNT_W + 1)'(resp_valid_i && dropping);
      live_d = live_q + PF_CNT_W'(issue_i) - PF_CNT_W'(keep);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      live_q <= '0;
      disc_q <= '0;
    end else begin
      live_q <= live_d;
      disc_q <= disc_d;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Bus must answer only what was accepted
  a_resp_expected: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_i |-> (live_q != '0 || disc_q != '0))
    else $error("response with no transaction outstanding");

endmodule

`default_nettype wire

//--- pf_buffer.sv
// Prefetch buffer FIFO for instruction words
// Registered occupancy, single-cycle flush
// Assertion on overflow

`timescale 1ns/1ps
`default_nettype none

module pf_buffer import pf_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush_i,
  // Write side from the response filter
  input  logic                 wr_en_i,
  input  logic [PF_DATA_W-1:0] wr_data_i,
  // Read side to the core
  input  logic                 rd_en_i,
  output logic                 rd_valid_o,
  output logic [PF_DATA_W-1:0] rd_data_o,
  output logic [PF_CNT_W-1:0]  count_o
);

  // Word storage
  logic [PF_DATA_W-1:0] mem_q [PF_DEPTH];

  logic [PF_PTR_W-1:0]  wr_ptr_q;
  logic [PF_PTR_W-1:0]  rd_ptr_q;
  logic [PF_CNT_W-1:0]  count_q;

  logic                 push;
  logic                 pop;

  // Flush wins over a write in the same cycle
  assign push = wr_en_i && !flush_i;
  // Read only when a word is there
  assign pop  = rd_en_i && rd_valid_o;

  assign rd_valid_o = (count_q != '0);
  assign rd_data_o  = mem_q[rd_ptr_q];
  assign count_o    = count_q;

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  ////////////////////
  // Pointers and occupancy
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Whole buffer dropped at once
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + PF_CNT_W'(push) - PF_CNT_W'(pop);
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Controller credit must keep room for every live response
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count_q != PF_CNT_W'(PF_DEPTH)))
    else $error("prefetch buffer written while full");

endmodule

`default_nettype wire

//--- prefetch_unit.sv
// Instruction prefetch unit top level
// Controller, address counters, response filter and prefetch buffer

`timescale 1ns/1ps
`default_nettype none

module prefetch_unit import pf_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  // Core fetch side
  input  logic                 fetch_valid_i,
  input  logic                 fetch_branch_i,
  input  logic [PF_ADDR_W-1:0] fetch_branch_addr_i,
  output logic                 fetch_ready_o,
  // Bus request
  output logic                 trans_valid_o,
  input  logic                 trans_ready_i,
  output logic [PF_ADDR_W-1:0] trans_addr_o,
  // Bus response
  input  logic                 resp_valid_i,
  input  logic [PF_DATA_W-1:0] resp_rdata_i,
  // Instruction output
  output logic                 instr_valid_o,
  input  logic                 instr_ready_i,
  output logic [PF_DATA_W-1:0] instr_rdata_o,
  output logic [PF_ADDR_W-1:0] instr_addr_o
);

  logic                 issue;
  logic                 flush;
  logic                 sel_branch;
  logic                 wr_en;
  logic [PF_DATA_W-1:0] wr_data;
  logic [PF_CNT_W-1:0]  outstanding;
  logic [PF_CNT_W-1:0]  count;
  logic                 instr_take;

  // Word leaves the buffer on the output handshake
  assign instr_take = instr_valid_o && instr_ready_i;

  pf_ctrl_fsm i_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_valid_i (fetch_valid_i),
    .fetch_branch_i(fetch_branch_i),
    .trans_ready_i (trans_ready_i),
    .count_i       (count),
    .outstanding_i (outstanding),
    .trans_valid_o (trans_valid_o),
    .fetch_ready_o (fetch_ready_o),
    .issue_o       (issue),
    .flush_o       (flush),
    .sel_branch_o  (sel_branch)
  );

  pf_addr_cnt i_addr_cnt (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_branch_i     (fetch_branch_i),
    .fetch_branch_addr_i(fetch_branch_addr_i),
    .sel_branch_i       (sel_branch),
    .issue_i            (issue),
    .pop_i              (instr_take),
    .trans_addr_o       (trans_addr_o),
    .instr_addr_o       (instr_addr_o)
  );

  pf_resp_filter i_resp_filter (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_i      (issue),
    .flush_i      (flush),
    .resp_valid_i (resp_valid_i),
    .resp_rdata_i (resp_rdata_i),
    .wr_en_o      (wr_en),
    .wr_data_o    (wr_data),
    .outstanding_o(outstanding)
  );

  pf_buffer i_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush_i   (flush),
    .wr_en_i   (wr_en),
    .wr_data_i (wr_data),
    .rd_en_i   (instr_take),
    .rd_valid_o(instr_valid_o),
    .rd_data_o (instr_rdata_o),
    .count_o   (count)
  );

endmodule

`default_nettype wire

//--- tb_prefetch_mem.sv
// Behavioral instruction bus memory for the prefetch unit testbench
// Random request stalls, in-order responses after 1 to 3 cycles
// Word at address A is A XOR a fixed key

`timescale 1ns/1ps
`default_nettype none

module tb_prefetch_mem import pf_pkg::*; #(
  parameter int unsigned          SEED     = 1,
  parameter logic [PF_DATA_W-1:0] WORD_KEY = '0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // Request side
  input  logic                 trans_valid_i,
  input  logic [PF_ADDR_W-1:0] trans_addr_i,
  output logic                 trans_ready_o,
  // Forces a request stall while high
  input  logic                 hold_ready_i,
  // Response side
  output logic                 resp_valid_o,
  output logic [PF_DATA_W-1:0] resp_rdata_o
);

  integer               seed;
  logic [31:0]          rnd;
  int                   cycle;
  int                   due;
  int                   last_due;
  logic                 rst_q;
  logic                 hold_q;

  // Accepted addresses and the cycle each one answers in
  logic [PF_ADDR_W-1:0] addr_q [$];
  int                   due_q  [$];

  initial begin
    seed          = SEED;
    trans_ready_o = 1'b0;
    resp_valid_o  = 1'b0;
    resp_rdata_o  = '0;
    cycle         = 0;
    last_due      = 0;
    rst_q         = 1'b0;
    hold_q        = 1'b0;
    forever begin
      // Drive phase, just after the rising edge
      @(posedge clk);
      #1;
      cycle++;
      resp_valid_o = 1'b0;
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        resp_valid_o = 1'b1;
        resp_rdata_o = addr_q[0] ^ WORD_KEY;
        addr_q.delete(0);
        due_q.delete(0);
      end
      // Roughly one stall in four
      rnd           = $random(seed);
      trans_ready_o = rst_q && !hold_q && (rnd[1:0] != 2'b00);

      // Sample phase, inputs settled
      @(negedge clk);
      rst_q  = rst_n;
      hold_q = hold_ready_i;
      if (!rst_n) begin
        addr_q.delete();
        due_q.delete();
        last_due = cycle;
      end else if (trans_valid_i && trans_ready_o) begin
        rnd = $random(seed);
        due = cycle + 1 + int'(rnd[7:0] % 3);
        // Keep responses in order, one per cycle at most
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        addr_q.push_back(trans_addr_i);
        due_q.push_back(due);
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_prefetch_unit.sv
// Testbench top for the instruction prefetch unit
// Clock, reset, stimulus table applied in a loop
// Stream monitor with address, data, credit and handshake checks

`timescale 1ns/1ps
`default_nettype none

module tb_prefetch_unit import pf_pkg::*; ();

  localparam int unsigned          SEED         = 34;
  localparam logic [PF_DATA_W-1:0] MEM_KEY      = 32'h5A5A_0000;
  localparam int                   TAKE_TIMEOUT = 400;

  logic                 clk;
  logic                 rst_n;
  logic                 fetch_valid_i;
  logic                 fetch_branch_i;
  logic [PF_ADDR_W-1:0] fetch_branch_addr_i;
  logic                 fetch_ready_o;
  logic                 trans_valid_o;
  logic                 trans_ready_i;
  logic [PF_ADDR_W-1:0] trans_addr_o;
  logic                 resp_valid_i;
  logic [PF_DATA_W-1:0] resp_rdata_i;
  logic                 instr_valid_o;
  logic                 instr_ready_i;
  logic [PF_DATA_W-1:0] instr_rdata_o;
  logic [PF_ADDR_W-1:0] instr_addr_o;
  logic                 hold_ready;

  // Stimulus table, one entry per branch
  logic [PF_ADDR_W-1:0] row_target [$];
  int                   row_take   [$];
  logic [7:0]           row_pat    [$];
  int                   row_hold   [$];
  bit                   row_drop   [$];
  bit                   row_stall  [$];

  // Expected stream state, reset on every branch
  logic [PF_ADDR_W-1:0] exp_addr;
  logic [PF_ADDR_W-1:0] exp_trans;
  int                   acc_cnt;
  int                   take_cnt;
  bit                   mon_en;
  int                   addr_errs;
  int                   word_errs;
  int                   bit_errs;

  prefetch_unit i_prefetch_unit (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_branch_i     (fetch_branch_i),
    .fetch_branch_addr_i(fetch_branch_addr_i),
    .fetch_ready_o      (fetch_ready_o),
    .trans_valid_o      (trans_valid_o),
    .trans_ready_i      (trans_ready_i),
    .trans_addr_o       (trans_addr_o),
    .resp_valid_i       (resp_valid_i),
    .resp_rdata_i       (resp_rdata_i),
    .instr_valid_o      (instr_valid_o),
    .instr_ready_i      (instr_ready_i),
    .instr_rdata_o      (instr_rdata_o),
    .instr_addr_o       (instr_addr_o)
  );

  tb_prefetch_mem #(.SEED(SEED), .WORD_KEY(MEM_KEY)) i_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .trans_valid_i(trans_valid_o),
    .trans_addr_i (trans_addr_o),
    .trans_ready_o(trans_ready_i),
    .hold_ready_i (hold_ready),
    .resp_valid_o (resp_valid_i),
    .resp_rdata_o (resp_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // Check tasks
  ////////////////////

  task automatic check_addr(input string name, input logic [PF_ADDR_W-1:0] got,
                            input logic [PF_ADDR_W-1:0] exp);
    if (got !== exp) begin
      addr_errs++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_word(input string name, input logic [PF_DATA_W-1:0] got,
                            input logic [PF_DATA_W-1:0] exp);
    if (got !== exp) begin
      word_errs++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errs++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////
  // Stream monitor
  ////////////////////

  // Sampled mid-cycle, all inputs settled
  always @(negedge clk) begin : monitor
    logic accept;
    if (mon_en) begin
      accept = trans_valid_o && trans_ready_i;
      check_bit("fetch_ready_o", fetch_ready_o, accept);
      if (!fetch_valid_i) begin
        check_bit("trans_valid_o", trans_valid_o, 1'b0);
      end
      if (accept) begin
        check_addr("trans_addr_o", trans_addr_o, {trans_addr_o[PF_ADDR_W-1:2], 2'b00});
        // First acceptance is the target, then one word apart
        check_addr("trans_addr_o", trans_addr_o, exp_trans);
        exp_trans = exp_trans + 32'd4;
        acc_cnt++;
      end
      if (instr_valid_o && instr_ready_i) begin
        check_addr("instr_addr_o", instr_addr_o, exp_addr);
        check_word("instr_rdata_o", instr_rdata_o, exp_addr ^ MEM_KEY);
        exp_addr = exp_addr + 32'd4;
        take_cnt++;
      end
      // Never more words in flight or buffered than the buffer holds
      check_bit("credit", (acc_cnt - take_cnt) <= int'(PF_DEPTH), 1'b1);
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic add_row(input logic [PF_ADDR_W-1:0] target, input int take,
                         input logic [7:0] pat, input int hold, input bit drop,
                         input bit stall);
    row_target.push_back(target);
    row_take.push_back(take);
    row_pat.push_back(pat);
    row_hold.push_back(hold);
    row_drop.push_back(drop);
    row_stall.push_back(stall);
  endtask

  // Branch pulse, with the bus optionally stalled around it
  task automatic start_branch(input int idx);
    if (row_stall[idx]) begin
      @(posedge clk);
      #1;
      hold_ready = 1'b1;
    end
    @(posedge clk);
    #1;
    fetch_valid_i       = 1'b1;
    fetch_branch_i      = 1'b1;
    fetch_branch_addr_i = row_target[idx];
    instr_ready_i       = 1'b0;
    exp_addr            = row_target[idx];
    exp_trans           = row_target[idx];
    acc_cnt             = 0;
    take_cnt            = 0;
    @(posedge clk);
    #1;
    fetch_branch_i      = 1'b0;
    fetch_branch_addr_i = '0;
  endtask

  // Take the row's words with its ready pattern
  task automatic consume_words(input int idx, output bit timed_out);
    int cycles;
    cycles    = 0;
    timed_out = 1'b0;
    while (take_cnt < row_take[idx] && !timed_out) begin
      @(posedge clk);
      #1;
      if (cycles == 3) begin
        hold_ready = 1'b0;
      end
      if (take_cnt >= row_take[idx]) begin
        instr_ready_i = 1'b0;
      end else if (cycles >= TAKE_TIMEOUT) begin
        timed_out = 1'b1;
      end else if (cycles < row_hold[idx]) begin
        instr_ready_i = 1'b0;
      end else begin
        instr_ready_i = row_pat[idx][cycles % 8];
      end
      cycles++;
    end
    instr_ready_i = 1'b0;
    hold_ready    = 1'b0;
  endtask

  initial begin
    bit timed_out;
    fetch_valid_i       = 1'b0;
    fetch_branch_i      = 1'b0;
    fetch_branch_addr_i = '0;
    instr_ready_i       = 1'b0;
    hold_ready          = 1'b0;
    mon_en              = 1'b0;
    exp_addr            = '0;
    exp_trans           = '0;
    acc_cnt             = 0;
    take_cnt            = 0;
    addr_errs           = 0;
    word_errs           = 0;
    bit_errs            = 0;
    timed_out           = 1'b0;

    // target, take, ready pattern, hold low, drop fetch, stall at branch
    add_row(32'h0000_1000, 12, 8'hFF,        0,  1'b0, 1'b0);
    add_row(32'h0000_2040, 6,  8'b1011_0110, 0,  1'b0, 1'b0);
    add_row(32'h0001_0000, 10, 8'hFF,        20, 1'b0, 1'b1);
    add_row(32'h0000_3FF0, 5,  8'b0101_0101, 0,  1'b1, 1'b0);
    add_row(32'h8000_0000, 9,  8'hFF,        0,  1'b0, 1'b1);
    add_row(32'hFFFF_FFF0, 8,  8'b1100_1110, 12, 1'b0, 1'b0);
    add_row(32'h0000_1000, 4,  8'hFF,        0,  1'b1, 1'b0);

    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Quiet outputs until the core asks
    repeat (4) begin
      @(negedge clk);
      check_bit("trans_valid_o", trans_valid_o, 1'b0);
      check_bit("fetch_ready_o", fetch_ready_o, 1'b0);
      check_bit("instr_valid_o", instr_valid_o, 1'b0);
    end
    @(posedge clk);
    #1;
    mon_en = 1'b1;

    for (int i = 0; i < row_target.size() && !timed_out; i++) begin
      start_branch(i);
      consume_words(i, timed_out);
      if (timed_out) begin
        $display("Timeout in row %0d, only %0d of %0d instructions taken",
                 i, take_cnt, row_take[i]);
      end else if (row_drop[i]) begin
        // Core stops asking while old responses drain
        fetch_valid_i = 1'b0;
        repeat (10) @(posedge clk);
      end
    end

    repeat (10) @(posedge clk);
    $display("Errors: addr %0d, word %0d, control %0d", addr_errs, word_errs, bit_errs);
    if (!timed_out && addr_errs + word_errs + bit_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- prefetch_unit.f
pf_pkg.sv
pf_ctrl_fsm.sv
pf_addr_cnt.sv
pf_resp_filter.sv
pf_buffer.sv
prefetch_unit.sv
tb_prefetch_mem.sv
tb_prefetch_unit.sv
